// File: flist.f
rtl/sifh_pkg.sv
rtl/hit_router.sv
rtl/hist_builder.sv
rtl/peak_readout.sv
rtl/sifh_top.sv
verification/sifh_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the histogram front end testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/100ps \
    --top-module sifh_tb \
    --Mdir "$BUILD_DIR" -o sifh_sim \
    -f flist.f
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

"./$BUILD_DIR/sifh_sim" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^Finished with no errors$" "$LOG_FILE"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// File: verification/sifh_tb.sv
`default_nettype none

module sifh_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CODE_BITS   = 8;
    localparam int FINE_BITS   = 4;
    // narrow counters, one frame gives a pixel enough stamps to saturate
    localparam int COUNT_BITS  = 4;
    localparam int PIXEL_NUM   = 4;
    localparam int DATA_NUM    = 2;
    localparam int ACQ_NUM     = 8;
    localparam int COARSE_BITS = CODE_BITS - FINE_BITS;
    localparam int PIX_W       = $clog2(PIXEL_NUM);
    localparam int SAT         = (1 << COUNT_BITS) - 1;
    localparam int TIMEOUT     = 200;

    logic                   clk;
    logic                   combin_res;
    logic                   tdc_valid;
    logic [CODE_BITS-1:0]   tdc_code;
    logic [COUNT_BITS-1:0]  hit_count;
    logic                   hit_count_valid;
    logic                   frame_done;
    logic                   peak_valid;
    logic [PIX_W-1:0]       peak_pixel;
    logic [COARSE_BITS-1:0] peak_ch;
    logic [FINE_BITS-1:0]   peak_fh;

    // model outputs, driven together with the stamp
    logic [COUNT_BITS-1:0]  exp_count;
    logic                   exp_last;
    // same values one cycle on, lined up with the DUT response
    logic                   stamp_q;
    logic [COUNT_BITS-1:0]  exp_count_q;
    logic                   last_q;
    // expected readout burst
    logic                   rd_act;
    logic [PIX_W-1:0]       rd_idx;

    // reference histograms per pixel
    int                     ch_cnt [PIXEL_NUM][1 << COARSE_BITS];
    int                     fh_cnt [PIXEL_NUM][1 << FINE_BITS];
    int                     ch_max [PIXEL_NUM];
    int                     fh_max [PIXEL_NUM];
    logic [COARSE_BITS-1:0] ch_peak [PIXEL_NUM];
    logic [FINE_BITS-1:0]   fh_peak [PIXEL_NUM];
    // previous frame coarse peaks
    logic [COARSE_BITS-1:0] win [PIXEL_NUM];
    // records expected in the next readout
    logic [COARSE_BITS-1:0] exp_ch [PIXEL_NUM];
    logic [FINE_BITS-1:0]   exp_fh [PIXEL_NUM];
    // bins the random codes lean toward
    logic [COARSE_BITS-1:0] tgt_c [PIXEL_NUM];
    logic [FINE_BITS-1:0]   tgt_f [PIXEL_NUM];

    int seed;
    int err_cnt;
    int test_cnt;

    sifh_top #(
        .CODE_BITS  (CODE_BITS),
        .FINE_BITS  (FINE_BITS),
        .COUNT_BITS (COUNT_BITS),
        .PIXEL_NUM  (PIXEL_NUM),
        .DATA_NUM   (DATA_NUM),
        .ACQ_NUM    (ACQ_NUM)
    ) i_dut (
        .clk             (clk),
        .combin_res      (combin_res),
        .tdc_valid       (tdc_valid),
        .tdc_code        (tdc_code),
        .hit_count       (hit_count),
        .hit_count_valid (hit_count_valid),
        .frame_done      (frame_done),
        .peak_valid      (peak_valid),
        .peak_pixel      (peak_pixel),
        .peak_ch         (peak_ch),
        .peak_fh         (peak_fh)
    );

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // one cycle latency for counts and frame end,
    // readout of PIXEL_NUM records right after frame_done
    always @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            stamp_q     <= 1'b0;
            exp_count_q <= '0;
            last_q      <= 1'b0;
            rd_act      <= 1'b0;
            rd_idx      <= '0;
        end else begin
            stamp_q     <= tdc_valid;
            exp_count_q <= exp_count;
            last_q      <= tdc_valid && exp_last;
            if (last_q) begin
                rd_act <= 1'b1;
                rd_idx <= '0;
            end else if (rd_act) begin
                if (rd_idx == PIX_W'(PIXEL_NUM - 1)) begin
                    rd_act <= 1'b0;
                    rd_idx <= '0;
                end else begin
                    rd_idx <= rd_idx + 1'b1;
                end
            end
        end
    end

    // checks sample on the falling edge, everything is settled there
    a_count_valid: assert property (@(negedge clk) disable iff (!combin_res)
        hit_count_valid == stamp_q)
    else begin
        err_cnt = err_cnt + 1;
        $display("mismatch hit_count_valid: got %h, expected %h", hit_count_valid, stamp_q);
    end

    a_count: assert property (@(negedge clk) disable iff (!combin_res)
        stamp_q |-> hit_count == exp_count_q)
    else begin
        err_cnt = err_cnt + 1;
        $display("mismatch hit_count: got %h, expected %h", hit_count, exp_count_q);
    end

    a_frame_done: assert property (@(negedge clk) disable iff (!combin_res)
        frame_done == last_q)
    else begin
        err_cnt = err_cnt + 1;
        $display("mismatch frame_done: got %h, expected %h", frame_done, last_q);
    end

    a_peak_valid: assert property (@(negedge clk) disable iff (!combin_res)
        peak_valid == rd_act)
    else begin
        err_cnt = err_cnt + 1;
        $display("mismatch peak_valid: got %h, expected %h", peak_valid, rd_act);
    end

    a_peak_pixel: assert property (@(negedge clk) disable iff (!combin_res)
        peak_valid |-> peak_pixel == rd_idx)
    else begin
        err_cnt = err_cnt + 1;
        $display("mismatch peak_pixel: got %h, expected %h", peak_pixel, rd_idx);
    end

    a_peak_ch: assert property (@(negedge clk) disable iff (!combin_res)
        peak_valid |-> peak_ch == exp_ch[rd_idx])
    else begin
        err_cnt = err_cnt + 1;
        $display("mismatch peak_ch: got %h, expected %h", peak_ch, exp_ch[rd_idx]);
    end

    a_peak_fh: assert property (@(negedge clk) disable iff (!combin_res)
        peak_valid |-> peak_fh == exp_fh[rd_idx])
    else begin
        err_cnt = err_cnt + 1;
        $display("mismatch peak_fh: got %h, expected %h", peak_fh, exp_fh[rd_idx]);
    end

    // empty histograms, peaks back at bin 0
    task automatic clear_counts();
        for (int p = 0; p < PIXEL_NUM; p++) begin
            for (int b = 0; b < (1 << COARSE_BITS); b++) begin
                ch_cnt[p][b] = 0;
            end
            for (int b = 0; b < (1 << FINE_BITS); b++) begin
                fh_cnt[p][b] = 0;
            end
            ch_max[p]  = 0;
            fh_max[p]  = 0;
            ch_peak[p] = '0;
            fh_peak[p] = '0;
        end
    endtask

    // snapshot peaks for readout, coarse peaks become next windows
    task automatic close_frame();
        for (int p = 0; p < PIXEL_NUM; p++) begin
            exp_ch[p] = ch_peak[p];
            exp_fh[p] = fh_peak[p];
            win[p]    = ch_peak[p];
        end
        clear_counts();
    endtask

    task automatic send_stamp(input int p, input logic [CODE_BITS-1:0] code,
                              input logic is_last);
        logic [COARSE_BITS-1:0] cb;
        logic [FINE_BITS-1:0]   fb;
        int                     nc;
        int                     nf;
        @(posedge clk);
        #5;
        cb = code[CODE_BITS-1:FINE_BITS];
        fb = code[FINE_BITS-1:0];
        // saturating count, strictly greater moves the peak
        nc = (ch_cnt[p][cb] >= SAT) ? SAT : ch_cnt[p][cb] + 1;
        ch_cnt[p][cb] = nc;
        if (nc > ch_max[p]) begin
            ch_max[p]  = nc;
            ch_peak[p] = cb;
        end
        // fine bins only inside last frame's coarse peak
        if (cb == win[p]) begin
            nf = (fh_cnt[p][fb] >= SAT) ? SAT : fh_cnt[p][fb] + 1;
            fh_cnt[p][fb] = nf;
            if (nf > fh_max[p]) begin
                fh_max[p]  = nf;
                fh_peak[p] = fb;
            end
        end
        tdc_valid = 1'b1;
        tdc_code  = code;
        exp_count = COUNT_BITS'(nc);
        exp_last  = is_last;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #5;
            tdc_valid = 1'b0;
            exp_last  = 1'b0;
        end
    endtask

    // mostly the target bins, now and then anywhere
    function automatic logic [CODE_BITS-1:0] pick_code(input int p);
        logic [31:0]            r;
        logic [COARSE_BITS-1:0] cb;
        logic [FINE_BITS-1:0]   fb;
        r  = $random(seed);
        cb = (r[1:0] != 2'b00) ? tgt_c[p] : r[11:8];
        fb = r[2] ? tgt_f[p] : r[15:12];
        return {cb, fb};
    endfunction

    task automatic wait_frame_done();
        int n;
        n = 0;
        while (!frame_done && n < TIMEOUT) begin
            @(posedge clk);
            #5;
            n++;
        end
        if (!frame_done) begin
            err_cnt = err_cnt + 1;
            $display("frame_done never came after the last stamp");
        end
    endtask

    task automatic wait_readout_end();
        int n;
        n = 0;
        while (!peak_valid && n < TIMEOUT) begin
            @(posedge clk);
            #5;
            n++;
        end
        if (!peak_valid) begin
            err_cnt = err_cnt + 1;
            $display("peak readout never started after frame_done");
        end
        n = 0;
        while (peak_valid && n < TIMEOUT) begin
            @(posedge clk);
            #5;
            n++;
        end
        if (peak_valid) begin
            err_cnt = err_cnt + 1;
            $display("peak readout did not end");
        end
    endtask

    // pixel order: acq sweep, then pixel, then stamp within pixel
    task automatic run_frame(input logic fixed);
        logic [CODE_BITS-1:0] code;
        logic                 is_last;
        for (int a = 0; a < ACQ_NUM; a++) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                for (int d = 0; d < DATA_NUM; d++) begin
                    code    = fixed ? {tgt_c[p], tgt_f[p]} : pick_code(p);
                    is_last = (a == ACQ_NUM - 1) && (p == PIXEL_NUM - 1) &&
                              (d == DATA_NUM - 1);
                    send_stamp(p, code, is_last);
                end
            end
        end
        close_frame();
        idle_cycles(1);
        wait_frame_done();
        wait_readout_end();
    endtask

    task automatic report_test(input string name, input int err_before);
        test_cnt++;
        $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err_before);
    endtask

    initial begin
        logic [31:0] r;
        int          err_before;
        seed       = 32'h1199;
        err_cnt    = 0;
        test_cnt   = 0;
        combin_res = 1'b0;
        tdc_valid  = 1'b0;
        tdc_code   = '0;
        exp_count  = '0;
        exp_last   = 1'b0;
        clear_counts();
        for (int p = 0; p < PIXEL_NUM; p++) begin
            win[p]    = '0;
            exp_ch[p] = '0;
            exp_fh[p] = '0;
            r         = $random(seed);
            // pixel 0 aims at coarse 0, inside the first frame's window
            tgt_c[p]  = (p == 0) ? '0 : r[7:4];
            tgt_f[p]  = r[3:0];
        end
        repeat (5) @(posedge clk);
        #5;
        combin_res = 1'b1;

        err_before = err_cnt;
        idle_cycles(20);
        report_test("idle after reset", err_before);

        err_before = err_cnt;
        run_frame(1'b0);
        report_test("frame 1 counts and peaks, window bin 0", err_before);

        err_before = err_cnt;
        run_frame(1'b0);
        report_test("frame 2 cleared counts, window from frame 1", err_before);

        // one code per pixel, more stamps than the counter holds
        err_before = err_cnt;
        run_frame(1'b1);
        report_test("frame 3 count saturation", err_before);

        idle_cycles(2);
        $display("tests: %0d, errors: %0d", test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/sifh_top.sv
`default_nettype none

module sifh_top import sifh_pkg::*; #(
    parameter int CODE_BITS  = def_code_bits,
    parameter int FINE_BITS  = def_fine_bits,
    parameter int COUNT_BITS = def_count_bits,
    parameter int PIXEL_NUM  = def_pixel_num,
    parameter int DATA_NUM   = def_data_num,
    parameter int ACQ_NUM    = def_acq_num,
    localparam int COARSE_BITS = CODE_BITS - FINE_BITS,
    localparam int PIX_W       = (PIXEL_NUM > 1) ? $clog2(PIXEL_NUM) : 1
) (
    input  wire logic                   clk,
    input  wire logic                   combin_res,
    input  wire logic                   tdc_valid,
    input  wire logic [CODE_BITS-1:0]   tdc_code,
    output logic [COUNT_BITS-1:0]       hit_count,
    output logic                        hit_count_valid,
    output logic                        frame_done,
    output logic                        peak_valid,
    output logic [PIX_W-1:0]            peak_pixel,
    output logic [COARSE_BITS-1:0]      peak_ch,
    output logic [FINE_BITS-1:0]        peak_fh
);

    // router to builders
    logic                         hit_stb;
    logic [PIX_W-1:0]             pixel_idx;
    logic [COARSE_BITS-1:0]       coarse_bin;
    logic [FINE_BITS-1:0]         fine_bin;
    logic                         fine_hit;
    logic                         frame_last;
    // readout back to router
    logic [COARSE_BITS-1:0]       window_bin;
    // builders to readout
    logic [PIXEL_NUM*COARSE_BITS-1:0] peak_ch_bins;
    logic [PIXEL_NUM*FINE_BITS-1:0]   peak_fh_bins;

    hit_router #(
        .CODE_BITS (CODE_BITS),
        .FINE_BITS (FINE_BITS),
        .PIXEL_NUM (PIXEL_NUM),
        .DATA_NUM  (DATA_NUM),
        .ACQ_NUM   (ACQ_NUM)
    ) u_router (
        .clk        (clk),
        .combin_res (combin_res),
        .tdc_valid  (tdc_valid),
        .tdc_code   (tdc_code),
        .window_bin (window_bin),
        .hit_stb    (hit_stb),
        .pixel_idx  (pixel_idx),
        .coarse_bin (coarse_bin),
        .fine_bin   (fine_bin),
        .fine_hit   (fine_hit),
        .frame_last (frame_last)
    );

    // coarse histogram counts every stamp, its frame pulse is frame_done
    hist_builder #(
        .BIN_BITS   (COARSE_BITS),
        .COUNT_BITS (COUNT_BITS),
        .PIXEL_NUM  (PIXEL_NUM)
    ) u_coarse (
        .clk         (clk),
        .combin_res  (combin_res),
        .hit_stb     (hit_stb),
        .pixel_idx   (pixel_idx),
        .bin         (coarse_bin),
        .count_en    (hit_stb),
        .frame_last  (frame_last),
        .count       (hit_count),
        .count_valid (hit_count_valid),
        .frame_clear (frame_done),
        .peak_bins   (peak_ch_bins)
    );

    // fine histogram only inside the window
    hist_builder #(
        .BIN_BITS   (FINE_BITS),
        .COUNT_BITS (COUNT_BITS),
        .PIXEL_NUM  (PIXEL_NUM)
    ) u_fine (
        .clk         (clk),
        .combin_res  (combin_res),
        .hit_stb     (hit_stb),
        .pixel_idx   (pixel_idx),
        .bin         (fine_bin),
        .count_en    (hit_stb && fine_hit),
        .frame_last  (frame_last),
        .count       (),
        .count_valid (),
        .frame_clear (),
        .peak_bins   (peak_fh_bins)
    );

    peak_readout #(
        .CODE_BITS (CODE_BITS),
        .FINE_BITS (FINE_BITS),
        .PIXEL_NUM (PIXEL_NUM)
    ) u_readout (
        .clk          (clk),
        .combin_res   (combin_res),
        .frame_clear  (frame_done),
        .peak_ch_bins (peak_ch_bins),
        .peak_fh_bins (peak_fh_bins),
        .pixel_idx    (pixel_idx),
        .window_bin   (window_bin),
        .peak_valid   (peak_valid),
        .peak_pixel   (peak_pixel),
        .peak_ch      (peak_ch),
        .peak_fh      (peak_fh)
    );

endmodule

`default_nettype wire

// File: rtl/peak_readout.sv
`default_nettype none

module peak_readout import sifh_pkg::*; #(
    parameter int CODE_BITS = def_code_bits,
    parameter int FINE_BITS = def_fine_bits,
    parameter int PIXEL_NUM = def_pixel_num,
    localparam int COARSE_BITS = CODE_BITS - FINE_BITS,
    localparam int PIX_W       = (PIXEL_NUM > 1) ? $clog2(PIXEL_NUM) : 1
) (
    input  wire logic                            clk,
    input  wire logic                            combin_res,
    input  wire logic                            frame_clear,
    input  wire logic [PIXEL_NUM*COARSE_BITS-1:0] peak_ch_bins,
    input  wire logic [PIXEL_NUM*FINE_BITS-1:0]   peak_fh_bins,
    input  wire logic [PIX_W-1:0]                pixel_idx,
    output logic [COARSE_BITS-1:0]               window_bin,
    output logic                                 peak_valid,
    output logic [PIX_W-1:0]                     peak_pixel,
    output logic [COARSE_BITS-1:0]               peak_ch,
    output logic [FINE_BITS-1:0]                 peak_fh
);

    // shadow copies of the frame's peaks
    // coarse copy doubles as next frame's fine window
    logic [PIXEL_NUM*COARSE_BITS-1:0] ch_shadow;
    logic [PIXEL_NUM*FINE_BITS-1:0]   fh_shadow;
    logic                             rd_last;

    assign rd_last = (peak_pixel == PIX_W'(PIXEL_NUM - 1));

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            ch_shadow  <= '0;
            fh_shadow  <= '0;
            peak_valid <= 1'b0;
            peak_pixel <= '0;
        end else if (frame_clear) begin
            // builders clear on this same edge, old peaks land here
            ch_shadow  <= peak_ch_bins;
            fh_shadow  <= peak_fh_bins;
            peak_valid <= 1'b1;
            peak_pixel <= '0;
        end else if (peak_valid) begin
            // one record per cycle, ascending pixels
            if (rd_last) begin
                peak_valid <= 1'b0;
                peak_pixel <= '0;
            end else begin
                peak_pixel <= peak_pixel + 1'b1;
            end
        end
    end

    // record fields
    assign peak_ch = ch_shadow[peak_pixel*COARSE_BITS +: COARSE_BITS];
    assign peak_fh = fh_shadow[peak_pixel*FINE_BITS +: FINE_BITS];

    // window for the pixel currently being stamped
    assign window_bin = ch_shadow[pixel_idx*COARSE_BITS +: COARSE_BITS];

    // a frame is far longer than the readout
    a_no_clear_in_readout: assert property (@(posedge clk) disable iff (!combin_res)
        frame_clear |-> !peak_valid);

endmodule

`default_nettype wire

// File: rtl/hist_builder.sv
`default_nettype none

module hist_builder import sifh_pkg::*; #(
    parameter int BIN_BITS   = def_coarse_bits,
    parameter int COUNT_BITS = def_count_bits,
    parameter int PIXEL_NUM  = def_pixel_num,
    localparam int PIX_W     = (PIXEL_NUM > 1) ? $clog2(PIXEL_NUM) : 1,
    localparam int ADDR_W    = PIX_W + BIN_BITS,
    // pixel index sits above the bin in the address
    localparam int MEM_DEPTH = PIXEL_NUM << BIN_BITS
) (
    input  wire logic                          clk,
    input  wire logic                          combin_res,
    input  wire logic                          hit_stb,
    input  wire logic [PIX_W-1:0]              pixel_idx,
    input  wire logic [BIN_BITS-1:0]           bin,
    input  wire logic                          count_en,
    input  wire logic                          frame_last,
    output logic [COUNT_BITS-1:0]              count,
    output logic                               count_valid,
    output logic                               frame_clear,
    output logic [PIXEL_NUM*BIN_BITS-1:0]      peak_bins
);

    // bin counters, all pixels in one array
    logic [COUNT_BITS-1:0]           bin_mem [MEM_DEPTH];
    // one valid bit per bin, cleared in a single cycle at frame end
    logic [MEM_DEPTH-1:0]            bin_vld;
    // running maximum count per pixel
    logic [PIXEL_NUM*COUNT_BITS-1:0] max_cnt;

    logic [ADDR_W-1:0]     addr;
    logic                  cnt_we;
    logic [COUNT_BITS-1:0] rd_count;
    logic [COUNT_BITS-1:0] new_count;
    logic [COUNT_BITS-1:0] cur_max;

    assign addr   = {pixel_idx, bin};
    assign cnt_we = hit_stb && count_en;

    // stale data behind a cleared valid bit reads as empty
    assign rd_count = bin_vld[addr] ? bin_mem[addr] : '0;

    // saturate at all ones
    assign new_count = (&rd_count) ? rd_count : rd_count + 1'b1;

    assign cur_max = max_cnt[pixel_idx*COUNT_BITS +: COUNT_BITS];

    // counter storage
    always_ff @(posedge clk) begin
        if (cnt_we) begin
            bin_mem[addr] <= new_count;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            bin_vld     <= '0;
            max_cnt     <= '0;
            peak_bins   <= '0;
            count       <= '0;
            count_valid <= 1'b0;
            frame_clear <= 1'b0;
        end else begin
            // frame end pulse, one cycle after the last stamp
            frame_clear <= hit_stb && frame_last;

            // per stamp count report
            count_valid <= cnt_we;
            if (cnt_we) begin
                count <= new_count;
            end

            if (frame_clear) begin
                // new frame starts empty, peaks back to bin 0
                bin_vld   <= '0;
                max_cnt   <= '0;
                peak_bins <= '0;
            end else if (cnt_we) begin
                bin_vld[addr] <= 1'b1;
                // strictly greater, ties keep the earlier bin
                if (new_count > cur_max) begin
                    max_cnt[pixel_idx*COUNT_BITS +: COUNT_BITS] <= new_count;
                    peak_bins[pixel_idx*BIN_BITS +: BIN_BITS]   <= bin;
                end
            end
        end
    end

    // router must never address a pixel outside the array
    a_pixel_range: assert property (@(posedge clk) disable iff (!combin_res)
        hit_stb |-> (pixel_idx < PIXEL_NUM));

endmodule

`default_nettype wire

// File: rtl/hit_router.sv
`default_nettype none

module hit_router import sifh_pkg::*; #(
    parameter int CODE_BITS = def_code_bits,
    parameter int FINE_BITS = def_fine_bits,
    parameter int PIXEL_NUM = def_pixel_num,
    parameter int DATA_NUM  = def_data_num,
    parameter int ACQ_NUM   = def_acq_num,
    // derived widths, guarded against single-entry counts
    localparam int COARSE_BITS = CODE_BITS - FINE_BITS,
    localparam int PIX_W       = (PIXEL_NUM > 1) ? $clog2(PIXEL_NUM) : 1,
    localparam int DATA_W      = (DATA_NUM > 1) ? $clog2(DATA_NUM) : 1,
    localparam int ACQ_W       = (ACQ_NUM > 1) ? $clog2(ACQ_NUM) : 1
) (
    input  wire logic                   clk,
    input  wire logic                   combin_res,
    input  wire logic                   tdc_valid,
    input  wire logic [CODE_BITS-1:0]   tdc_code,
    input  wire logic [COARSE_BITS-1:0] window_bin,
    output logic                        hit_stb,
    output logic [PIX_W-1:0]            pixel_idx,
    output logic [COARSE_BITS-1:0]      coarse_bin,
    output logic [FINE_BITS-1:0]        fine_bin,
    output logic                        fine_hit,
    output logic                        frame_last
);

    // nested position counters: stamp within pixel, pixel within sweep,
    // sweep within frame
    logic [DATA_W-1:0] data_cnt;
    logic [PIX_W-1:0]  pix_cnt;
    logic [ACQ_W-1:0]  acq_cnt;
    logic              data_last;
    logic              pix_last;
    logic              acq_last;

    assign data_last = (data_cnt == DATA_W'(DATA_NUM - 1));
    assign pix_last  = (pix_cnt == PIX_W'(PIXEL_NUM - 1));
    assign acq_last  = (acq_cnt == ACQ_W'(ACQ_NUM - 1));

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            data_cnt <= '0;
            pix_cnt  <= '0;
            acq_cnt  <= '0;
        end else if (tdc_valid) begin
            // ripple carry through the three levels
            if (data_last) begin
                data_cnt <= '0;
                if (pix_last) begin
                    pix_cnt <= '0;
                    if (acq_last) begin
                        acq_cnt <= '0;
                    end else begin
                        acq_cnt <= acq_cnt + 1'b1;
                    end
                end else begin
                    pix_cnt <= pix_cnt + 1'b1;
                end
            end else begin
                data_cnt <= data_cnt + 1'b1;
            end
        end
    end

    // stamp passes straight through, builders register it
    assign hit_stb    = tdc_valid;
    assign pixel_idx  = pix_cnt;
    assign coarse_bin = tdc_code[CODE_BITS-1:FINE_BITS];
    assign fine_bin   = tdc_code[FINE_BITS-1:0];

    // fine histogram only sees stamps inside last frame's coarse peak
    assign fine_hit   = (coarse_bin == window_bin);

    // final stamp of the frame
    assign frame_last = data_last && pix_last && acq_last;

    // source must idle while the builders clear and readout captures
    a_idle_after_frame: assert property (@(posedge clk) disable iff (!combin_res)
        (tdc_valid && frame_last) |=> !tdc_valid [*2]);

    // counters wrap at their limits
    a_cnt_range: assert property (@(posedge clk) disable iff (!combin_res)
        (data_cnt < DATA_NUM) && (pix_cnt < PIXEL_NUM) && (acq_cnt < ACQ_NUM));

endmodule

`default_nettype wire

// File: rtl/sifh_pkg.sv
`default_nettype none

package sifh_pkg;

    // time stamp code from the TDC
    // full code width in bits
    localparam int def_code_bits = 8;

    // lower code bits forming the fine bin
    localparam int def_fine_bits = 4;

    // upper bits left over for the coarse bin
    localparam int def_coarse_bits = def_code_bits - def_fine_bits;

    // histogram bin counters
    // saturating, so all ones is the ceiling
    localparam int def_count_bits = 8;

    // acquisition order
    // pixels visited in one sweep
    localparam int def_pixel_num = 4;

    // stamps taken from each pixel per sweep
    localparam int def_data_num = 2;

    // sweeps making up one frame
    localparam int def_acq_num = 8;

    // one frame is pixel_num * data_num * acq_num stamps,
    // readout needs pixel_num cycles, always far shorter than a frame

endpackage

`default_nettype wire
